/* id_pkg.sv */
package id_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int INST_W     = 32;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // bl writes the return address here
    localparam reg_addr_t LINK_REG = 5'd1;

    // bits 31:22, immediate, load and store forms
    localparam logic [9:0] OPC10_SLTI  = 10'h008;
    localparam logic [9:0] OPC10_SLTUI = 10'h009;
    localparam logic [9:0] OPC10_ADDI  = 10'h00a;
    localparam logic [9:0] OPC10_ANDI  = 10'h00d;
    localparam logic [9:0] OPC10_ORI   = 10'h00e;
    localparam logic [9:0] OPC10_XORI  = 10'h00f;
    localparam logic [9:0] OPC10_LDB   = 10'h0a0;
    localparam logic [9:0] OPC10_LDH   = 10'h0a1;
    localparam logic [9:0] OPC10_LDW   = 10'h0a2;
    localparam logic [9:0] OPC10_STB   = 10'h0a4;
    localparam logic [9:0] OPC10_STH   = 10'h0a5;
    localparam logic [9:0] OPC10_STW   = 10'h0a6;
    localparam logic [9:0] OPC10_LDBU  = 10'h0a8;
    localparam logic [9:0] OPC10_LDHU  = 10'h0a9;

    // bits 31:15, register-register and shift-immediate forms
    localparam logic [16:0] OPC17_ADD  = 17'h00020;
    localparam logic [16:0] OPC17_SUB  = 17'h00022;
    localparam logic [16:0] OPC17_SLT  = 17'h00024;
    localparam logic [16:0] OPC17_SLTU = 17'h00025;
    localparam logic [16:0] OPC17_NOR  = 17'h00028;
    localparam logic [16:0] OPC17_AND  = 17'h00029;
    localparam logic [16:0] OPC17_OR   = 17'h0002a;
    localparam logic [16:0] OPC17_XOR  = 17'h0002b;
    localparam logic [16:0] OPC17_SLL  = 17'h0002e;
    localparam logic [16:0] OPC17_SRL  = 17'h0002f;
    localparam logic [16:0] OPC17_SRA  = 17'h00030;
    localparam logic [16:0] OPC17_SLLI = 17'h00081;
    localparam logic [16:0] OPC17_SRLI = 17'h00089;
    localparam logic [16:0] OPC17_SRAI = 17'h00091;

    localparam logic [6:0] OPC7_LU12I     = 7'h0a;
    localparam logic [6:0] OPC7_PCADDU12I = 7'h0e;

    localparam logic [5:0] OPC6_JIRL = 6'h13;
    localparam logic [5:0] OPC6_B    = 6'h14;
    localparam logic [5:0] OPC6_BL   = 6'h15;
    localparam logic [5:0] OPC6_BEQ  = 6'h16;
    localparam logic [5:0] OPC6_BNE  = 6'h17;
    localparam logic [5:0] OPC6_BLT  = 6'h18;
    localparam logic [5:0] OPC6_BGE  = 6'h19;
    localparam logic [5:0] OPC6_BLTU = 6'h1a;
    localparam logic [5:0] OPC6_BGEU = 6'h1b;

    typedef enum logic [5:0] {
        ALU_NOP = 6'd0,
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_NOR, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_SLTI, ALU_SLTUI, ALU_ADDI, ALU_ANDI, ALU_ORI, ALU_XORI,
        ALU_SLLI, ALU_SRLI, ALU_SRAI, ALU_LU12I, ALU_PCADDU12I,
        ALU_LDB, ALU_LDH, ALU_LDW, ALU_LDBU, ALU_LDHU, ALU_STB, ALU_STH, ALU_STW,
        ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU, ALU_B, ALU_BL, ALU_JIRL
    } alu_op_e;

    typedef enum logic [2:0] {
        SEL_NOP = 3'd0,
        SEL_LOGIC,
        SEL_SHIFT,
        SEL_ARITH,
        SEL_LOAD_STORE,
        SEL_JUMP_BRANCH
    } alu_sel_e;

    typedef enum logic [2:0] {
        IMM_NONE = 3'd0,
        IMM_SEXT12,
        IMM_ZEXT12,
        IMM_UIMM5,
        IMM_UPPER20,
        IMM_PC_UPPER20
    } imm_kind_e;

    typedef struct packed {
        alu_op_e   aluop;
        alu_sel_e  alusel;
        logic      rd1_en;
        reg_addr_t rd1_addr;
        logic      rd2_en;
        reg_addr_t rd2_addr;
        logic      wr_en;
        reg_addr_t wr_addr;
        word_t     imm;
        imm_kind_e imm_kind;
        word_t     br_offset;
        logic      br_use_reg;
    } dec_ctrl_t;

    typedef struct packed {
        logic      en;
        reg_addr_t addr;
        word_t     data;
    } fwd_t;

    typedef struct packed {
        logic      en;
        reg_addr_t addr;
        word_t     data;
    } wb_t;

    typedef struct packed {
        logic  taken;
        word_t target;
        word_t link;
    } branch_t;

    typedef struct packed {
        alu_op_e   aluop;
        alu_sel_e  alusel;
        word_t     reg1;
        word_t     reg2;
        logic      wr_en;
        reg_addr_t wr_addr;
        word_t     link;
        word_t     pc;
    } id_ex_t;

    localparam id_ex_t ID_EX_BUBBLE = '0;

endpackage

/* id_decoder.sv */
`timescale 1ns/1ps

module id_decoder
    import id_pkg::*;
(
    input  word_t     inst_i,
    output dec_ctrl_t ctrl_o
);

    logic [9:0]  opc10;
    logic [16:0] opc17;
    logic [6:0]  opc7;
    logic [5:0]  opc6;
    reg_addr_t   rd;
    reg_addr_t   rj;
    reg_addr_t   rk;
    word_t       off16;
    word_t       off26;

    assign opc10 = inst_i[INST_W-1 -: 10];
    assign opc17 = inst_i[INST_W-1 -: 17];
    assign opc7  = inst_i[INST_W-1 -: 7];
    assign opc6  = inst_i[INST_W-1 -: 6];

    assign rk = inst_i[14:10];
    assign rj = inst_i[9:5];
    assign rd = inst_i[4:0];

    // word offsets, scaled to bytes
    assign off16 = {{14{inst_i[25]}}, inst_i[25:10], 2'b00};
    assign off26 = {{4{inst_i[9]}}, inst_i[9:0], inst_i[25:10], 2'b00};

    function automatic dec_ctrl_t pick(
        input alu_op_e   op,
        input alu_sel_e  sel,
        input logic      rd1_en,
        input logic      rd2_en,
        input logic      wr_en,
        input imm_kind_e kind
    );
        dec_ctrl_t c;
        c          = '0;
        c.aluop    = op;
        c.alusel   = sel;
        c.rd1_en   = rd1_en;
        c.rd2_en   = rd2_en;
        c.wr_en    = wr_en;
        c.imm_kind = kind;
        return c;
    endfunction

    always_comb begin
        ctrl_o = '0;

        case (opc17)
            OPC17_ADD:  ctrl_o = pick(ALU_ADD,  SEL_ARITH, 1'b1, 1'b1, 1'b1, IMM_NONE);
            OPC17_SUB:  ctrl_o = pick(ALU_SUB,  SEL_ARITH, 1'b1, 1'b1, 1'b1, IMM_NONE);
            OPC17_SLT:  ctrl_o = pick(ALU_SLT,  SEL_ARITH, 1'b1, 1'b1, 1'b1, IMM_NONE);
            OPC17_SLTU: ctrl_o = pick(ALU_SLTU, SEL_ARITH, 1'b1, 1'b1, 1'b1, IMM_NONE);
            OPC17_NOR:  ctrl_o = pick(ALU_NOR,  SEL_LOGIC, 1'b1, 1'b1, 1'b1, IMM_NONE);
            OPC17_AND:  ctrl_o = pick(ALU_AND,  SEL_LOGIC, 1'b1, 1'b1, 1'b1, IMM_NONE);
            OPC17_OR:   ctrl_o = pick(ALU_OR,   SEL_LOGIC, 1'b1, 1'b1, 1'b1, IMM_NONE);
            OPC17_XOR:  ctrl_o = pick(ALU_XOR,  SEL_LOGIC, 1'b1, 1'b1, 1'b1, IMM_NONE);
            OPC17_SLL:  ctrl_o = pick(ALU_SLL,  SEL_SHIFT, 1'b1, 1'b1, 1'b1, IMM_NONE);
            OPC17_SRL:  ctrl_o = pick(ALU_SRL,  SEL_SHIFT, 1'b1, 1'b1, 1'b1, IMM_NONE);
            OPC17_SRA:  ctrl_o = pick(ALU_SRA,  SEL_SHIFT, 1'b1, 1'b1, 1'b1, IMM_NONE);
            OPC17_SLLI: ctrl_o = pick(ALU_SLLI, SEL_SHIFT, 1'b1, 1'b0, 1'b1, IMM_UIMM5);
            OPC17_SRLI: ctrl_o = pick(ALU_SRLI, SEL_SHIFT, 1'b1, 1'b0, 1'b1, IMM_UIMM5);
            OPC17_SRAI: ctrl_o = pick(ALU_SRAI, SEL_SHIFT, 1'b1, 1'b0, 1'b1, IMM_UIMM5);
            default: ;
        endcase

        case (opc10)
            OPC10_SLTI:  ctrl_o = pick(ALU_SLTI,  SEL_ARITH, 1'b1, 1'b0, 1'b1, IMM_SEXT12);
            OPC10_SLTUI: ctrl_o = pick(ALU_SLTUI, SEL_ARITH, 1'b1, 1'b0, 1'b1, IMM_SEXT12);
            OPC10_ADDI:  ctrl_o = pick(ALU_ADDI,  SEL_ARITH, 1'b1, 1'b0, 1'b1, IMM_SEXT12);
            OPC10_ANDI:  ctrl_o = pick(ALU_ANDI,  SEL_LOGIC, 1'b1, 1'b0, 1'b1, IMM_ZEXT12);
            OPC10_ORI:   ctrl_o = pick(ALU_ORI,   SEL_LOGIC, 1'b1, 1'b0, 1'b1, IMM_ZEXT12);
            OPC10_XORI:  ctrl_o = pick(ALU_XORI,  SEL_LOGIC, 1'b1, 1'b0, 1'b1, IMM_ZEXT12);
            OPC10_LDB:  ctrl_o = pick(ALU_LDB,  SEL_LOAD_STORE, 1'b1, 1'b0, 1'b1, IMM_SEXT12);
            OPC10_LDH:  ctrl_o = pick(ALU_LDH,  SEL_LOAD_STORE, 1'b1, 1'b0, 1'b1, IMM_SEXT12);
            OPC10_LDW:  ctrl_o = pick(ALU_LDW,  SEL_LOAD_STORE, 1'b1, 1'b0, 1'b1, IMM_SEXT12);
            OPC10_LDBU: ctrl_o = pick(ALU_LDBU, SEL_LOAD_STORE, 1'b1, 1'b0, 1'b1, IMM_SEXT12);
            OPC10_LDHU: ctrl_o = pick(ALU_LDHU, SEL_LOAD_STORE, 1'b1, 1'b0, 1'b1, IMM_SEXT12);
            OPC10_STB:  ctrl_o = pick(ALU_STB,  SEL_LOAD_STORE, 1'b1, 1'b1, 1'b0, IMM_SEXT12);
            OPC10_STH:  ctrl_o = pick(ALU_STH,  SEL_LOAD_STORE, 1'b1, 1'b1, 1'b0, IMM_SEXT12);
            OPC10_STW:  ctrl_o = pick(ALU_STW,  SEL_LOAD_STORE, 1'b1, 1'b1, 1'b0, IMM_SEXT12);
            default: ;
        endcase

        case (opc7)
            OPC7_LU12I:
                ctrl_o = pick(ALU_LU12I, SEL_LOGIC, 1'b1, 1'b0, 1'b1, IMM_UPPER20);
            OPC7_PCADDU12I:
                ctrl_o = pick(ALU_PCADDU12I, SEL_ARITH, 1'b0, 1'b0, 1'b1, IMM_PC_UPPER20);
            default: ;
        endcase

        case (opc6)
            OPC6_BEQ:  ctrl_o = pick(ALU_BEQ,  SEL_JUMP_BRANCH, 1'b1, 1'b1, 1'b0, IMM_NONE);
            OPC6_BNE:  ctrl_o = pick(ALU_BNE,  SEL_JUMP_BRANCH, 1'b1, 1'b1, 1'b0, IMM_NONE);
            OPC6_BLT:  ctrl_o = pick(ALU_BLT,  SEL_JUMP_BRANCH, 1'b1, 1'b1, 1'b0, IMM_NONE);
            OPC6_BGE:  ctrl_o = pick(ALU_BGE,  SEL_JUMP_BRANCH, 1'b1, 1'b1, 1'b0, IMM_NONE);
            OPC6_BLTU: ctrl_o = pick(ALU_BLTU, SEL_JUMP_BRANCH, 1'b1, 1'b1, 1'b0, IMM_NONE);
            OPC6_BGEU: ctrl_o = pick(ALU_BGEU, SEL_JUMP_BRANCH, 1'b1, 1'b1, 1'b0, IMM_NONE);
            OPC6_B:    ctrl_o = pick(ALU_B,    SEL_JUMP_BRANCH, 1'b0, 1'b0, 1'b0, IMM_NONE);
            OPC6_BL:   ctrl_o = pick(ALU_BL,   SEL_JUMP_BRANCH, 1'b0, 1'b0, 1'b1, IMM_NONE);
            OPC6_JIRL: ctrl_o = pick(ALU_JIRL, SEL_JUMP_BRANCH, 1'b1, 1'b1, 1'b1, IMM_NONE);
            default: ;
        endcase

        // unmatched words stay as the all-zero NOP bundle
        if (ctrl_o.alusel != SEL_NOP) begin
            ctrl_o.rd1_addr = (ctrl_o.aluop == ALU_LU12I) ? '0 : rj;
            // stores and branches take their second source from rd
            if (ctrl_o.rd2_en && ctrl_o.alusel inside {SEL_LOAD_STORE, SEL_JUMP_BRANCH}) begin
                ctrl_o.rd2_addr = rd;
            end else begin
                ctrl_o.rd2_addr = rk;
            end
            ctrl_o.wr_addr = (ctrl_o.aluop == ALU_BL) ? LINK_REG : rd;

            case (ctrl_o.imm_kind)
                IMM_SEXT12:                  ctrl_o.imm = {{20{inst_i[21]}}, inst_i[21:10]};
                IMM_ZEXT12:                  ctrl_o.imm = {20'b0, inst_i[21:10]};
                IMM_UIMM5:                   ctrl_o.imm = {27'b0, inst_i[14:10]};
                IMM_UPPER20, IMM_PC_UPPER20: ctrl_o.imm = {inst_i[24:5], 12'b0};
                default:                     ctrl_o.imm = '0;
            endcase

            if (ctrl_o.alusel == SEL_JUMP_BRANCH) begin
                ctrl_o.br_offset  = (ctrl_o.aluop inside {ALU_B, ALU_BL}) ? off26 : off16;
                ctrl_o.br_use_reg = (ctrl_o.aluop == ALU_JIRL);
            end
        end
    end

endmodule

/* id_regfile.sv */
`timescale 1ns/1ps

module id_regfile
    import id_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  wb_t       wb_i,
    input  reg_addr_t rd1_addr_i,
    input  reg_addr_t rd2_addr_i,
    output word_t     rd1_data_o,
    output word_t     rd2_data_o
);

    // r0 has no storage
    word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.en && wb_i.addr != '0) begin
            regs[wb_i.addr] <= wb_i.data;
        end
    end

    // no write bypass, a write shows up the cycle after
    assign rd1_data_o = (rd1_addr_i == '0) ? '0 : regs[rd1_addr_i];
    assign rd2_data_o = (rd2_addr_i == '0) ? '0 : regs[rd2_addr_i];

endmodule

/* id_operand_sel.sv */
`timescale 1ns/1ps

module id_operand_sel
    import id_pkg::*;
(
    input  dec_ctrl_t ctrl_i,
    input  word_t     pc_i,
    input  word_t     rf1_i,
    input  word_t     rf2_i,
    input  fwd_t      ex_fwd_i,
    input  fwd_t      mem_fwd_i,
    output word_t     reg1_o,
    output word_t     reg2_o
);

    // EX result is younger than MEM, so it wins
    function automatic word_t resolve(
        input logic      en,
        input reg_addr_t addr,
        input word_t     rf,
        input fwd_t      ex,
        input fwd_t      mem,
        input word_t     imm
    );
        word_t val;
        if (!en) begin
            val = imm;
        end else if (ex.en && ex.addr == addr) begin
            val = ex.data;
        end else if (mem.en && mem.addr == addr) begin
            val = mem.data;
        end else begin
            val = rf;
        end
        return val;
    endfunction

    // pcaddu12i adds the upper immediate to the pc
    assign reg1_o = (ctrl_i.imm_kind == IMM_PC_UPPER20) ? pc_i :
                    resolve(ctrl_i.rd1_en, ctrl_i.rd1_addr, rf1_i, ex_fwd_i, mem_fwd_i,
                            ctrl_i.imm);

    assign reg2_o = resolve(ctrl_i.rd2_en, ctrl_i.rd2_addr, rf2_i, ex_fwd_i, mem_fwd_i,
                            ctrl_i.imm);

endmodule

/* id_branch_resolve.sv */
`timescale 1ns/1ps

module id_branch_resolve
    import id_pkg::*;
(
    input  dec_ctrl_t ctrl_i,
    input  word_t     pc_i,
    input  word_t     reg1_i,
    input  word_t     reg2_i,
    input  logic      pause_i,
    output branch_t   branch_o
);

    logic  cond;
    logic  is_link;
    word_t base;

    always_comb begin
        cond = 1'b0;
        case (ctrl_i.aluop)
            ALU_BEQ:  cond = (reg1_i == reg2_i);
            ALU_BNE:  cond = (reg1_i != reg2_i);
            ALU_BLT:  cond = ($signed(reg1_i) < $signed(reg2_i));
            ALU_BGE:  cond = ($signed(reg1_i) >= $signed(reg2_i));
            ALU_BLTU: cond = (reg1_i < reg2_i);
            ALU_BGEU: cond = (reg1_i >= reg2_i);
            ALU_B, ALU_BL, ALU_JIRL: begin
                cond = 1'b1;
            end
            default: cond = 1'b0;
        endcase
    end

    assign is_link = (ctrl_i.aluop == ALU_BL) || (ctrl_i.aluop == ALU_JIRL);

    // jirl jumps relative to rj, all others relative to pc
    assign base = ctrl_i.br_use_reg ? reg1_i : pc_i;

    always_comb begin
        // a stalled instruction is held and redecoded, so its branch waits
        branch_o.taken  = cond && !pause_i;
        branch_o.target = base + ctrl_i.br_offset;
        branch_o.link   = is_link ? pc_i + 32'd4 : '0;
    end

endmodule

/* id_ex_reg.sv */
`timescale 1ns/1ps

module id_ex_reg
    import id_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  dec_ctrl_t ctrl_i,
    input  word_t     pc_i,
    input  word_t     reg1_i,
    input  word_t     reg2_i,
    input  word_t     link_i,
    output id_ex_t    id_ex_o,
    output logic      pause_o
);

    logic ex_is_load;
    logic rd1_hit;
    logic rd2_hit;

    // the entry held here is the one now in EX
    assign ex_is_load = id_ex_o.wr_en &&
                        (id_ex_o.aluop inside {ALU_LDB, ALU_LDH, ALU_LDW, ALU_LDBU, ALU_LDHU});

    assign rd1_hit = ctrl_i.rd1_en && (ctrl_i.rd1_addr == id_ex_o.wr_addr);
    assign rd2_hit = ctrl_i.rd2_en && (ctrl_i.rd2_addr == id_ex_o.wr_addr);

    // load data is not ready until MEM, one bubble covers the gap
    assign pause_o = ex_is_load && (rd1_hit || rd2_hit);

    always_ff @(posedge clk) begin
        if (rst || pause_o) begin
            id_ex_o <= ID_EX_BUBBLE;
        end else begin
            id_ex_o.aluop   <= ctrl_i.aluop;
            id_ex_o.alusel  <= ctrl_i.alusel;
            id_ex_o.reg1    <= reg1_i;
            id_ex_o.reg2    <= reg2_i;
            id_ex_o.wr_en   <= ctrl_i.wr_en;
            id_ex_o.wr_addr <= ctrl_i.wr_addr;
            id_ex_o.link    <= link_i;
            id_ex_o.pc      <= pc_i;
        end
    end

endmodule

/* id_stage_top.sv */
`timescale 1ns/1ps

module id_stage_top
    import id_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  word_t   pc_i,
    input  word_t   inst_i,
    input  wb_t     wb_i,
    input  fwd_t    ex_fwd_i,
    input  fwd_t    mem_fwd_i,
    output id_ex_t  id_ex_o,
    output branch_t branch_o,
    output logic    pause_o
);

    dec_ctrl_t ctrl;
    word_t     rf1_data;
    word_t     rf2_data;
    word_t     reg1;
    word_t     reg2;

    id_decoder id_decoder_inst (
        .inst_i (inst_i),
        .ctrl_o (ctrl)
    );

    id_regfile id_regfile_inst (
        .clk        (clk),
        .rst        (rst),
        .wb_i       (wb_i),
        .rd1_addr_i (ctrl.rd1_addr),
        .rd2_addr_i (ctrl.rd2_addr),
        .rd1_data_o (rf1_data),
        .rd2_data_o (rf2_data)
    );

    id_operand_sel id_operand_sel_inst (
        .ctrl_i    (ctrl),
        .pc_i      (pc_i),
        .rf1_i     (rf1_data),
        .rf2_i     (rf2_data),
        .ex_fwd_i  (ex_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .reg1_o    (reg1),
        .reg2_o    (reg2)
    );

    id_branch_resolve id_branch_resolve_inst (
        .ctrl_i   (ctrl),
        .pc_i     (pc_i),
        .reg1_i   (reg1),
        .reg2_i   (reg2),
        .pause_i  (pause_o),
        .branch_o (branch_o)
    );

    id_ex_reg id_ex_reg_inst (
        .clk     (clk),
        .rst     (rst),
        .ctrl_i  (ctrl),
        .pc_i    (pc_i),
        .reg1_i  (reg1),
        .reg2_i  (reg2),
        .link_i  (branch_o.link),
        .id_ex_o (id_ex_o),
        .pause_o (pause_o)
    );

endmodule

/* id_stage_assertions.sv */
`timescale 1ns/1ps

module id_stage_assertions
    import id_pkg::*;
(
    input logic   clk,
    input logic   rst,
    input logic   pause_i,
    input id_ex_t id_ex_i
);

    // a paused instruction leaves a bubble in the register
    assert property (@(posedge clk) disable iff (rst) pause_i |=> (id_ex_i == '0))
        else $error("no bubble in id_ex after a pause cycle");

    // the bubble clears the hazard, so pause lasts one cycle
    assert property (@(posedge clk) disable iff (rst) pause_i |=> !pause_i)
        else $error("pause held high for two consecutive cycles");

    assert property (@(posedge clk) rst |=> (id_ex_i == '0))
        else $error("id_ex not a bubble in the cycle after reset");

endmodule

bind id_ex_reg id_stage_assertions id_stage_assertions_inst (
    .clk     (clk),
    .rst     (rst),
    .pause_i (pause_o),
    .id_ex_i (id_ex_o)
);

/* tb_id_checks.svh */
`ifndef TB_ID_CHECKS_SVH
`define TB_ID_CHECKS_SVH

task automatic check_id_ex(input id_ex_t got, input id_ex_t exp, input string what);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("ERROR t=%0t: %s id_ex mismatch", $time, what);
        $display("    got op %s sel %s r1 %h r2 %h wr %b/%0d link %h pc %h",
                 got.aluop.name(), got.alusel.name(), got.reg1, got.reg2,
                 got.wr_en, got.wr_addr, got.link, got.pc);
        $display("    exp op %s sel %s r1 %h r2 %h wr %b/%0d link %h pc %h",
                 exp.aluop.name(), exp.alusel.name(), exp.reg1, exp.reg2,
                 exp.wr_en, exp.wr_addr, exp.link, exp.pc);
    end
endtask

task automatic check_branch(input branch_t got, input branch_t exp, input string what);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("ERROR t=%0t: %s branch got taken %b target %h link %h, expected %b %h %h",
                 $time, what, got.taken, got.target, got.link,
                 exp.taken, exp.target, exp.link);
    end
endtask

task automatic check_pause(input logic got, input logic exp, input string what);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("ERROR t=%0t: %s pause got %b expected %b", $time, what, got, exp);
    end
endtask

`endif

/* tb_id_stage.sv */
`timescale 1ns/1ps

module tb_id_stage
    import id_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 400;

    logic    clk;
    logic    rst;
    word_t   pc;
    word_t   inst;
    wb_t     wb;
    fwd_t    ex_fwd;
    fwd_t    mem_fwd;
    id_ex_t  id_ex;
    branch_t branch;
    logic    pause;

    // what the register file should hold
    word_t shadow [32];
    int    seed = 32'h925a;
    int    cycle_count = 0;
    int    check_count = 0;
    int    error_count = 0;
    int    test_count = 0;
    int    errors_at_start = 0;

    `include "tb_id_checks.svh"

    id_stage_top id_stage_top_inst (
        .clk       (clk),
        .rst       (rst),
        .pc_i      (pc),
        .inst_i    (inst),
        .wb_i      (wb),
        .ex_fwd_i  (ex_fwd),
        .mem_fwd_i (mem_fwd),
        .id_ex_o   (id_ex),
        .branch_o  (branch),
        .pause_o   (pause)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: tests still running after %0d cycles", cycle_count);
            $display("Simulation FAILED");
            $finish;
        end
    end

    function automatic word_t enc_3r(logic [16:0] opc, reg_addr_t rd, reg_addr_t rj,
                                     reg_addr_t rk);
        return {opc, rk, rj, rd};
    endfunction

    function automatic word_t enc_ri12(logic [9:0] opc, reg_addr_t rd, reg_addr_t rj,
                                       logic [11:0] imm);
        return {opc, imm, rj, rd};
    endfunction

    function automatic word_t enc_ri20(logic [6:0] opc, reg_addr_t rd, logic [19:0] imm);
        return {opc, imm, rd};
    endfunction

    function automatic word_t enc_br16(logic [5:0] opc, reg_addr_t rj, reg_addr_t rd,
                                       logic [15:0] offs);
        return {opc, offs, rj, rd};
    endfunction

    // high offset bits sit in the low ten bits of the word
    function automatic word_t enc_br26(logic [5:0] opc, logic [25:0] offs);
        return {opc, offs[15:0], offs[25:16]};
    endfunction

    function automatic id_ex_t entry(alu_op_e op, alu_sel_e sel, word_t r1, word_t r2,
                                     logic wr_en, reg_addr_t wr_addr, word_t link,
                                     word_t at_pc);
        id_ex_t e;
        e.aluop   = op;
        e.alusel  = sel;
        e.reg1    = r1;
        e.reg2    = r2;
        e.wr_en   = wr_en;
        e.wr_addr = wr_addr;
        e.link    = link;
        e.pc      = at_pc;
        return e;
    endfunction

    function automatic branch_t outcome(logic taken, word_t target, word_t link);
        branch_t b;
        b.taken  = taken;
        b.target = target;
        b.link   = link;
        return b;
    endfunction

    task automatic present(input word_t word, input word_t addr);
        pc   = addr;
        inst = word;
        #1;
    endtask

    task automatic advance();
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic write_reg(input reg_addr_t addr, input word_t data);
        wb.en   = 1'b1;
        wb.addr = addr;
        wb.data = data;
        @(negedge clk);
        wb.en = 1'b0;
        if (addr != '0) begin
            shadow[addr] = data;
        end
    endtask

    task automatic end_test(input string name);
        test_count++;
        if (error_count == errors_at_start) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, error_count - errors_at_start);
        end
        errors_at_start = error_count;
    endtask

    task automatic test_reset();
        check_id_ex(id_ex, '0, "reset");
        check_pause(pause, 1'b0, "reset");
        check_pause(branch.taken, 1'b0, "reset taken");
        end_test("reset");
    endtask

    task automatic run_reg_op(input logic [16:0] opc, input alu_op_e op, input alu_sel_e sel,
                              input reg_addr_t rd, input reg_addr_t rj, input reg_addr_t rk);
        present(enc_3r(opc, rd, rj, rk), 32'h1c000040 + rd);
        advance();
        check_id_ex(id_ex, entry(op, sel, shadow[rj], shadow[rk], 1'b1, rd, '0, pc),
                    op.name());
    endtask

    task automatic test_reg_ops();
        for (int i = 1; i < 32; i++) begin
            write_reg(reg_addr_t'(i), word_t'($random(seed)));
        end
        run_reg_op(OPC17_ADD, ALU_ADD, SEL_ARITH, 5'd10, 5'd1, 5'd20);
        run_reg_op(OPC17_SUB, ALU_SUB, SEL_ARITH, 5'd11, 5'd2, 5'd21);
        run_reg_op(OPC17_SLTU, ALU_SLTU, SEL_ARITH, 5'd12, 5'd3, 5'd22);
        run_reg_op(OPC17_NOR, ALU_NOR, SEL_LOGIC, 5'd13, 5'd4, 5'd23);
        run_reg_op(OPC17_XOR, ALU_XOR, SEL_LOGIC, 5'd14, 5'd5, 5'd24);
        run_reg_op(OPC17_SRA, ALU_SRA, SEL_SHIFT, 5'd15, 5'd6, 5'd25);
        // r0 keeps reading zero after a write
        write_reg(5'd0, 32'hdeadbeef);
        run_reg_op(OPC17_OR, ALU_OR, SEL_LOGIC, 5'd16, 5'd0, 5'd7);
        end_test("reg_ops");
    endtask

    task automatic run_imm(input word_t word, input alu_op_e op, input alu_sel_e sel,
                           input word_t r1, input word_t r2, input reg_addr_t rd);
        present(word, 32'h1c000400);
        advance();
        check_id_ex(id_ex, entry(op, sel, r1, r2, 1'b1, rd, '0, pc), op.name());
    endtask

    task automatic test_immediates();
        run_imm(enc_ri12(OPC10_ADDI, 5'd8, 5'd2, 12'hf80), ALU_ADDI, SEL_ARITH,
                shadow[2], 32'hffffff80, 5'd8);
        run_imm(enc_ri12(OPC10_SLTI, 5'd9, 5'd3, 12'h7ff), ALU_SLTI, SEL_ARITH,
                shadow[3], 32'h000007ff, 5'd9);
        run_imm(enc_ri12(OPC10_ANDI, 5'd8, 5'd4, 12'hf80), ALU_ANDI, SEL_LOGIC,
                shadow[4], 32'h00000f80, 5'd8);
        run_imm(enc_ri12(OPC10_ORI, 5'd8, 5'd5, 12'h9a5), ALU_ORI, SEL_LOGIC,
                shadow[5], 32'h000009a5, 5'd8);
        run_imm(enc_ri12(OPC10_XORI, 5'd8, 5'd6, 12'h801), ALU_XORI, SEL_LOGIC,
                shadow[6], 32'h00000801, 5'd8);
        run_imm(enc_3r(OPC17_SRAI, 5'd9, 5'd7, 5'd17), ALU_SRAI, SEL_SHIFT,
                shadow[7], 32'd17, 5'd9);
        run_imm(enc_ri20(OPC7_LU12I, 5'd9, 20'h8abcd), ALU_LU12I, SEL_LOGIC,
                '0, 32'h8abcd000, 5'd9);
        run_imm(enc_ri20(OPC7_PCADDU12I, 5'd10, 20'h00123), ALU_PCADDU12I, SEL_ARITH,
                32'h1c000400, 32'h00123000, 5'd10);
        end_test("immediates");
    endtask

    task automatic test_forwarding();
        word_t w;
        w = enc_3r(OPC17_ADD, 5'd12, 5'd3, 5'd4);
        ex_fwd  = '{en: 1'b1, addr: 5'd3, data: 32'haaaa0001};
        mem_fwd = '{en: 1'b1, addr: 5'd3, data: 32'hbbbb0001};
        present(w, 32'h1c000800);
        advance();
        check_id_ex(id_ex, entry(ALU_ADD, SEL_ARITH, 32'haaaa0001, shadow[4], 1'b1, 5'd12,
                                 '0, pc), "ex over mem");
        ex_fwd.addr = 5'd9;
        advance();
        check_id_ex(id_ex, entry(ALU_ADD, SEL_ARITH, 32'hbbbb0001, shadow[4], 1'b1, 5'd12,
                                 '0, pc), "mem over regfile");
        ex_fwd  = '{en: 1'b0, addr: 5'd3, data: 32'haaaa0002};
        mem_fwd = '{en: 1'b0, addr: 5'd4, data: 32'hbbbb0002};
        advance();
        check_id_ex(id_ex, entry(ALU_ADD, SEL_ARITH, shadow[3], shadow[4], 1'b1, 5'd12,
                                 '0, pc), "disabled sources");
        mem_fwd.en = 1'b1;
        advance();
        check_id_ex(id_ex, entry(ALU_ADD, SEL_ARITH, shadow[3], 32'hbbbb0002, 1'b1, 5'd12,
                                 '0, pc), "mem on rk");
        ex_fwd  = '0;
        mem_fwd = '0;
        end_test("forwarding");
    endtask

    task automatic run_branch(input word_t word, input branch_t exp, input string what);
        present(word, 32'h1c001000);
        check_branch(branch, exp, what);
        advance();
    endtask

    task automatic test_branches();
        word_t at;
        word_t off16;
        word_t off26;
        at    = 32'h1c001000;
        off16 = {{14{1'b1}}, 16'hfff0, 2'b00};
        off26 = {{4{1'b0}}, 26'h0000123, 2'b00};
        write_reg(5'd14, 32'h80000000);
        write_reg(5'd15, 32'h00000001);
        run_branch(enc_br16(OPC6_BEQ, 5'd15, 5'd15, 16'hfff0), outcome(1'b1, at + off16, '0),
                   "beq equal");
        run_branch(enc_br16(OPC6_BEQ, 5'd14, 5'd15, 16'hfff0), outcome(1'b0, at + off16, '0),
                   "beq differ");
        run_branch(enc_br16(OPC6_BNE, 5'd15, 5'd15, 16'hfff0), outcome(1'b0, at + off16, '0),
                   "bne equal");
        run_branch(enc_br16(OPC6_BLT, 5'd14, 5'd15, 16'hfff0), outcome(1'b1, at + off16, '0),
                   "blt signed");
        run_branch(enc_br16(OPC6_BLTU, 5'd14, 5'd15, 16'hfff0), outcome(1'b0, at + off16, '0),
                   "bltu unsigned");
        run_branch(enc_br26(OPC6_B, 26'h3fffff0), outcome(1'b1, at + off16, '0), "b");
        run_branch(enc_br16(OPC6_JIRL, 5'd15, 5'd1, 16'h0010),
                   outcome(1'b1, shadow[15] + 32'd64, at + 32'd4), "jirl");
        present(enc_br26(OPC6_BL, 26'h0000123), at);
        check_branch(branch, outcome(1'b1, at + off26, at + 32'd4), "bl");
        advance();
        check_id_ex(id_ex, entry(ALU_BL, SEL_JUMP_BRANCH, '0, '0, 1'b1, LINK_REG,
                                 at + 32'd4, at), "bl entry");
        end_test("branches");
    endtask

    task automatic test_load_use();
        word_t add_w;
        word_t beq_at;
        add_w  = enc_3r(OPC17_ADD, 5'd6, 5'd5, 5'd7);
        beq_at = 32'h1c00201c;
        present(enc_ri12(OPC10_LDW, 5'd5, 5'd4, 12'h010), 32'h1c002000);
        advance();
        present(add_w, 32'h1c002004);
        check_pause(pause, 1'b1, "ld then add");
        advance();
        check_id_ex(id_ex, '0, "bubble after pause");
        // fetch holds the add while the load result comes from MEM
        mem_fwd = '{en: 1'b1, addr: 5'd5, data: 32'h5a5a0005};
        #1;
        check_pause(pause, 1'b0, "pause clears");
        advance();
        check_id_ex(id_ex, entry(ALU_ADD, SEL_ARITH, 32'h5a5a0005, shadow[7], 1'b1, 5'd6,
                                 '0, 32'h1c002004), "add after bubble");
        mem_fwd = '0;
        present(enc_ri12(OPC10_LDW, 5'd5, 5'd4, 12'h020), 32'h1c002008);
        advance();
        present(enc_ri12(OPC10_STW, 5'd5, 5'd2, 12'h004), 32'h1c00200c);
        check_pause(pause, 1'b1, "ld then st");
        advance();
        check_id_ex(id_ex, '0, "bubble before store");
        check_pause(pause, 1'b0, "store pause clears");
        advance();
        present(enc_ri12(OPC10_ADDI, 5'd5, 5'd2, 12'h001), 32'h1c002010);
        advance();
        present(add_w, 32'h1c002014);
        check_pause(pause, 1'b0, "addi then add");
        advance();
        check_id_ex(id_ex, entry(ALU_ADD, SEL_ARITH, shadow[5], shadow[7], 1'b1, 5'd6,
                                 '0, 32'h1c002014), "add after addi");
        // a branch on the load result waits out the bubble
        present(enc_ri12(OPC10_LDW, 5'd5, 5'd4, 12'h030), 32'h1c002018);
        advance();
        present(enc_br16(OPC6_BEQ, 5'd5, 5'd5, 16'h0004), beq_at);
        check_pause(pause, 1'b1, "ld then beq");
        check_branch(branch, outcome(1'b0, beq_at + 32'd16, '0), "taken while paused");
        advance();
        check_branch(branch, outcome(1'b1, beq_at + 32'd16, '0), "beq after bubble");
        end_test("load_use");
    endtask

    initial begin
        rst     = 1'b1;
        pc      = '0;
        inst    = '0;
        wb      = '0;
        ex_fwd  = '0;
        mem_fwd = '0;
        for (int i = 0; i < 32; i++) begin
            shadow[i] = '0;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #1;

        test_reset();
        test_reg_ops();
        test_immediates();
        test_forwarding();
        test_branches();
        test_load_use();

        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+.
id_pkg.sv
id_decoder.sv
id_regfile.sv
id_operand_sel.sv
id_branch_resolve.sv
id_ex_reg.sv
id_stage_top.sv
id_stage_assertions.sv
tb_id_stage.sv

/* run.sh */
#!/bin/sh
# build and run the ID stage testbench, pass only if the pass message shows up
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_id_stage \
    -f list.f -o tb_id_stage_sim &&
./obj_dir/tb_id_stage_sim | tee /dev/stderr | grep -q "Simulation PASSED" &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }
